// File: rtl/dma_rd_pkg.sv
package dma_rd_pkg;

    // Bus widths, fixed for the whole read path
    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int AXI_LEN_WIDTH = 8;

    // arsize code for 4-byte beats
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

    // arburst encodings
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

    // rresp codes, ORed together along a command
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_EXOKAY = 2'b01;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;
    localparam logic [1:0] AXI_RESP_DECERR = 2'b11;

    // No incrementing burst may cross this boundary
    localparam int PAGE_BYTES = 4096;

    // Command from the host side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [15:0]       byte_len;
        logic              fixed;
        logic              lock;
    } dma_cmd_t;

    // One legal burst, len is beats minus one
    typedef struct packed {
        logic [ADDR_W-1:0]        addr;
        logic [AXI_LEN_WIDTH-1:0] len;
        logic                     fixed;
        logic                     lock;
        logic                     cmd_last;
    } dma_req_t;

    typedef struct packed {
        logic [1:0] resp;
    } dma_status_t;

    // AR channel payload, single ID
    typedef struct packed {
        logic [ADDR_W-1:0]        addr;
        logic [AXI_LEN_WIDTH-1:0] len;
        logic [2:0]               size;
        logic [1:0]               burst;
        logic                     lock;
    } axi_ar_t;

    // R channel payload
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // Data FIFO entry, cmd_last set on the final word of a command
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              cmd_last;
    } fifo_word_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } strm_t;

endpackage

// File: rtl/dma_burst_split.sv
module dma_burst_split #(
    parameter int MAX_BEATS = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dma_rd_pkg::dma_cmd_t    i_cmd,
    input  logic                    i_cmd_valid,
    output logic                    o_cmd_ready,
    output dma_rd_pkg::dma_req_t    o_req,
    output logic                    o_req_valid,
    input  logic                    i_req_ready,
    input  logic [1:0]              i_burst_resp,
    input  logic                    i_burst_resp_valid,
    output dma_rd_pkg::dma_status_t o_status,
    output logic                    o_status_valid
);
    import dma_rd_pkg::*;

    localparam int PAGE_AW    = $clog2(PAGE_BYTES);
    localparam int PAGE_WORDS = PAGE_BYTES / 4;
    localparam int BEATS_W    = 14;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_SPLIT = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;

    logic [1:0]         state;
    logic [ADDR_W-1:0]  cur_addr;
    logic [BEATS_W-1:0] beats_left;
    logic               cur_fixed;
    logic               cur_lock;
    logic [BEATS_W-1:0] page_words;
    logic [BEATS_W-1:0] burst_beats;
    logic               req_fire;
    logic               last_burst;
    logic [2:0]         outstanding;
    logic [1:0]         status_acc;

    // Words left before the next page boundary
    always_comb page_words = BEATS_W'(PAGE_WORDS) - BEATS_W'(cur_addr[PAGE_AW-1:2]);

    // Burst length is the minimum of the three limits
    always_comb begin
        burst_beats = BEATS_W'(MAX_BEATS);
        // Fixed bursts stay on one address, page limit does not apply
        if (!cur_fixed && page_words < burst_beats) begin
            burst_beats = page_words;
        end
        if (beats_left < burst_beats) begin
            burst_beats = beats_left;
        end
    end

    always_comb last_burst = (burst_beats == beats_left);

    always_comb begin
        o_req.addr     = cur_addr;
        o_req.len      = AXI_LEN_WIDTH'(burst_beats - BEATS_W'(1));
        o_req.fixed    = cur_fixed;
        o_req.lock     = cur_lock;
        o_req.cmd_last = last_burst;
    end

    always_comb o_req_valid = (state == S_SPLIT);
    always_comb o_cmd_ready = (state == S_IDLE);
    always_comb req_fire    = o_req_valid && i_req_ready;

    // Address and remaining length of the command in progress
    always_ff @(posedge clk) begin
        if (o_cmd_ready && i_cmd_valid) begin
            cur_addr   <= i_cmd.addr;
            beats_left <= i_cmd.byte_len[15:2];
            cur_fixed  <= i_cmd.fixed;
            cur_lock   <= i_cmd.lock;
        end else if (req_fire) begin
            beats_left <= beats_left - burst_beats;
            if (!cur_fixed) begin
                cur_addr <= cur_addr + ADDR_W'({burst_beats, 2'b00});
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            outstanding    <= 3'd0;
            status_acc     <= AXI_RESP_OKAY;
            o_status       <= '0;
            o_status_valid <= 1'b0;
        end else begin
            o_status_valid <= 1'b0;

            // Bursts issued but not yet answered, at most three
            case ({req_fire, i_burst_resp_valid})
                2'b10:   outstanding <= outstanding + 3'd1;
                2'b01:   outstanding <= outstanding - 3'd1;
                default: outstanding <= outstanding;
            endcase

            if (i_burst_resp_valid) begin
                status_acc <= status_acc | i_burst_resp;
            end

            case (state)
                S_IDLE: begin
                    if (i_cmd_valid) begin
                        status_acc <= AXI_RESP_OKAY;
                        state      <= S_SPLIT;
                    end
                end
                S_SPLIT: begin
                    if (req_fire && last_burst) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // Responses return in order, the last one closes the command
                    if (i_burst_resp_valid && outstanding == 3'd1) begin
                        o_status.resp  <= status_acc | i_burst_resp;
                        o_status_valid <= 1'b1;
                        state          <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/axi_mgr_rd.sv
module axi_mgr_rd (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dma_rd_pkg::dma_req_t   i_req,
    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    output dma_rd_pkg::axi_ar_t    o_ar,
    output logic                   o_arvalid,
    input  logic                   i_arready,
    input  dma_rd_pkg::axi_r_t     i_r,
    input  logic                   i_rvalid,
    output logic                   o_rready,
    output dma_rd_pkg::fifo_word_t o_push,
    output logic                   o_push_valid,
    input  logic                   i_push_ready,
    output logic [1:0]             o_burst_resp,
    output logic                   o_burst_resp_valid
);
    import dma_rd_pkg::*;

    // Two-entry context buffer
    dma_req_t   ctx [2];
    logic [1:0] ctx_sent;
    logic [1:0] ctx_count;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       nxt_ptr;

    logic       ar_idx;
    logic       ar_fire;
    logic       req_fire;
    logic       head_active;
    logic       r_fire;
    logic       burst_done;
    logic [1:0] resp_acc;
    dma_req_t   ar_ctx;
    dma_req_t   head_ctx;

    always_comb nxt_ptr  = ~rd_ptr;
    always_comb head_ctx = ctx[rd_ptr];

    // Head drives AR until sent, then the entry behind it may go out
    always_comb ar_idx = ctx_sent[rd_ptr] ? nxt_ptr : rd_ptr;
    always_comb ar_ctx = ctx[ar_idx];

    always_comb begin
        o_arvalid = ((ctx_count != 2'd0) && !ctx_sent[rd_ptr]) ||
                    ((ctx_count == 2'd2) && !ctx_sent[nxt_ptr]);
        o_ar.addr  = ar_ctx.addr;
        o_ar.len   = ar_ctx.len;
        o_ar.size  = AXI_SIZE_WORD;
        o_ar.burst = ar_ctx.fixed ? AXI_BURST_FIXED : AXI_BURST_INCR;
        o_ar.lock  = ar_ctx.lock;
    end

    always_comb ar_fire     = o_arvalid && i_arready;
    always_comb o_req_ready = (ctx_count != 2'd2);
    always_comb req_fire    = i_req_valid && o_req_ready;

    // Data returns for the head once its AR is out
    always_comb head_active = (ctx_count != 2'd0) && ctx_sent[rd_ptr];
    always_comb o_rready    = head_active && i_push_ready;
    always_comb r_fire      = i_rvalid && o_rready;
    always_comb burst_done  = r_fire && i_r.last;

    // Beats go straight to the FIFO
    always_comb begin
        o_push_valid    = i_rvalid && head_active;
        o_push.data     = i_r.data;
        o_push.cmd_last = i_r.last && head_ctx.cmd_last;
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            ctx[wr_ptr] <= i_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_sent  <= 2'b00;
            ctx_count <= 2'd0;
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
        end else begin
            if (req_fire) begin
                wr_ptr <= ~wr_ptr;
            end
            if (ar_fire) begin
                ctx_sent[ar_idx] <= 1'b1;
            end
            // Head retires on its rlast beat
            if (burst_done) begin
                ctx_sent[rd_ptr] <= 1'b0;
                rd_ptr           <= nxt_ptr;
            end
            case ({req_fire, burst_done})
                2'b10:   ctx_count <= ctx_count + 2'd1;
                2'b01:   ctx_count <= ctx_count - 2'd1;
                default: ctx_count <= ctx_count;
            endcase
        end
    end

    // OR of rresp over the burst, reported after rlast
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_acc           <= AXI_RESP_OKAY;
            o_burst_resp       <= AXI_RESP_OKAY;
            o_burst_resp_valid <= 1'b0;
        end else begin
            o_burst_resp_valid <= 1'b0;
            if (burst_done) begin
                o_burst_resp       <= resp_acc | i_r.resp;
                o_burst_resp_valid <= 1'b1;
                resp_acc           <= AXI_RESP_OKAY;
            end else if (r_fire) begin
                resp_acc <= resp_acc | i_r.resp;
            end
        end
    end

endmodule

// File: rtl/rd_data_fifo.sv
module rd_data_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dma_rd_pkg::fifo_word_t i_push,
    input  logic                   i_push_valid,
    output logic                   o_push_ready,
    output dma_rd_pkg::fifo_word_t o_pop,
    output logic                   o_pop_valid,
    input  logic                   i_pop_ready
);
    import dma_rd_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fifo_word_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    always_comb o_pop_valid = (count != CNT_W'(0));
    always_comb o_pop       = mem[rd_ptr];

    // A full FIFO still takes a word when one leaves in the same cycle
    always_comb o_push_ready = (count != CNT_W'(FIFO_DEPTH)) || i_pop_ready;

    always_comb push_fire = i_push_valid && o_push_ready;
    always_comb pop_fire  = o_pop_valid && i_pop_ready;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= i_push;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the depth, which need not be a power of two
            if (push_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/dma_stream_out.sv
module dma_stream_out (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dma_rd_pkg::fifo_word_t i_pop,
    input  logic                   i_pop_valid,
    output logic                   o_pop_ready,
    output dma_rd_pkg::strm_t      o_strm,
    output logic                   o_strm_valid,
    input  logic                   i_strm_ready,
    output logic [15:0]            o_word_count
);
    import dma_rd_pkg::*;

    logic pop_fire;
    logic new_cmd;

    // Load when the register is empty or its word is leaving
    always_comb o_pop_ready = !o_strm_valid || i_strm_ready;
    always_comb pop_fire    = i_pop_valid && o_pop_ready;

    // Output word, held under back-pressure
    always_ff @(posedge clk) begin
        if (pop_fire) begin
            o_strm.data <= i_pop.data;
            o_strm.last <= i_pop.cmd_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_strm_valid <= 1'b0;
        end else if (pop_fire) begin
            o_strm_valid <= 1'b1;
        end else if (i_strm_ready) begin
            o_strm_valid <= 1'b0;
        end
    end

    // Word index within the command, kept after last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_word_count <= 16'd0;
            new_cmd      <= 1'b1;
        end else if (pop_fire) begin
            // First word after a last restarts the count
            if (new_cmd) begin
                o_word_count <= 16'd1;
            end else begin
                o_word_count <= o_word_count + 16'd1;
            end
            new_cmd <= i_pop.cmd_last;
        end
    end

endmodule

// File: rtl/dma_rd_top.sv
module dma_rd_top #(
    parameter int MAX_BEATS  = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dma_rd_pkg::dma_cmd_t    i_cmd,
    input  logic                    i_cmd_valid,
    output logic                    o_cmd_ready,
    output dma_rd_pkg::axi_ar_t     o_ar,
    output logic                    o_arvalid,
    input  logic                    i_arready,
    input  dma_rd_pkg::axi_r_t      i_r,
    input  logic                    i_rvalid,
    output logic                    o_rready,
    output dma_rd_pkg::strm_t       o_strm,
    output logic                    o_strm_valid,
    input  logic                    i_strm_ready,
    output logic [15:0]             o_word_count,
    output dma_rd_pkg::dma_status_t o_status,
    output logic                    o_status_valid
);
    import dma_rd_pkg::*;

    // Splitter to manager
    dma_req_t   req;
    logic       req_valid;
    logic       req_ready;
    logic [1:0] burst_resp;
    logic       burst_resp_valid;

    // Manager to FIFO
    fifo_word_t push;
    logic       push_valid;
    logic       push_ready;

    // FIFO to output stage
    fifo_word_t pop;
    logic       pop_valid;
    logic       pop_ready;

    dma_burst_split #(
        .MAX_BEATS (MAX_BEATS)
    ) dma_burst_split_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_cmd              (i_cmd),
        .i_cmd_valid        (i_cmd_valid),
        .o_cmd_ready        (o_cmd_ready),
        .o_req              (req),
        .o_req_valid        (req_valid),
        .i_req_ready        (req_ready),
        .i_burst_resp       (burst_resp),
        .i_burst_resp_valid (burst_resp_valid),
        .o_status           (o_status),
        .o_status_valid     (o_status_valid)
    );

    axi_mgr_rd axi_mgr_rd_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_req              (req),
        .i_req_valid        (req_valid),
        .o_req_ready        (req_ready),
        .o_ar               (o_ar),
        .o_arvalid          (o_arvalid),
        .i_arready          (i_arready),
        .i_r                (i_r),
        .i_rvalid           (i_rvalid),
        .o_rready           (o_rready),
        .o_push             (push),
        .o_push_valid       (push_valid),
        .i_push_ready       (push_ready),
        .o_burst_resp       (burst_resp),
        .o_burst_resp_valid (burst_resp_valid)
    );

    rd_data_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rd_data_fifo_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_push       (push),
        .i_push_valid (push_valid),
        .o_push_ready (push_ready),
        .o_pop        (pop),
        .o_pop_valid  (pop_valid),
        .i_pop_ready  (pop_ready)
    );

    dma_stream_out dma_stream_out_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_pop        (pop),
        .i_pop_valid  (pop_valid),
        .o_pop_ready  (pop_ready),
        .o_strm       (o_strm),
        .o_strm_valid (o_strm_valid),
        .i_strm_ready (i_strm_ready),
        .o_word_count (o_word_count)
    );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, starts low
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

// File: verif/tb_axi_mem.sv
module tb_axi_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  dma_rd_pkg::axi_ar_t i_ar,
    input  logic                i_arvalid,
    output logic                o_arready,
    output dma_rd_pkg::axi_r_t  o_r,
    output logic                o_rvalid,
    input  logic                i_rready
);
    timeunit 1ns;
    timeprecision 1ps;
    import dma_rd_pkg::*;

    // Accepted bursts, served strictly in order
    axi_ar_t     ar_q [$];
    int unsigned beat;
    logic        ar_fire;
    logic        r_fire;
    axi_ar_t     ar_in;

    // Data is the beat address, upper half of the map answers SLVERR
    function automatic axi_r_t beat_word(input axi_ar_t ar, input int unsigned idx);
        axi_r_t            w;
        logic [ADDR_W-1:0] a;
        if (ar.burst == AXI_BURST_FIXED) begin
            a = ar.addr;
        end else begin
            a = ar.addr + ADDR_W'(idx * 4);
        end
        w.data = a;
        w.resp = (a >= 32'h8000_0000) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        w.last = (idx == 32'(ar.len));
        return w;
    endfunction

    initial begin
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
        beat      = 0;
        forever begin
            @(posedge clk);
            // Handshakes as seen at the edge
            ar_fire = i_arvalid && o_arready;
            r_fire  = o_rvalid && i_rready;
            ar_in   = i_ar;
            #10;
            if (!rst_n) begin
                ar_q.delete();
                beat      = 0;
                o_arready = 1'b0;
                o_rvalid  = 1'b0;
            end else begin
                if (ar_fire) begin
                    ar_q.push_back(ar_in);
                end
                if (r_fire) begin
                    if (o_r.last) begin
                        ar_q.delete(0);
                        beat = 0;
                    end else begin
                        beat++;
                    end
                end
                // Up to four queued bursts, ready has random holes
                o_arready = (ar_q.size() < 4) && ($urandom_range(0, 3) != 0);
                // A beat on offer stays until taken
                if (!(o_rvalid && !r_fire)) begin
                    if (ar_q.size() != 0 && $urandom_range(0, 3) != 0) begin
                        o_rvalid = 1'b1;
                        o_r      = beat_word(ar_q[0], beat);
                    end else begin
                        o_rvalid = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: verif/dma_rd_chk.sv
module dma_rd_chk (
    input logic                clk,
    input logic                rst_n,
    input dma_rd_pkg::axi_ar_t i_ar,
    input logic                i_arvalid,
    input logic                i_arready,
    input logic                i_rready,
    input dma_rd_pkg::strm_t   i_strm,
    input logic                i_strm_valid,
    input logic                i_strm_ready,
    input logic                i_status_valid,
    input logic                i_cmd_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // AR request held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_ar))
        else begin
            fail_count++;
            $error("AR request dropped or changed before arready");
        end

    // Output word frozen under back-pressure
    strm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_strm_valid && !i_strm_ready |=> i_strm_valid && $stable(i_strm))
        else begin
            fail_count++;
            $error("Stream word dropped or changed while stalled");
        end

    // Quiet outputs while in reset
    rst_quiet: assert property (@(posedge clk)
        !rst_n |-> !i_arvalid && !i_rready && !i_strm_valid && !i_status_valid && i_cmd_ready)
        else begin
            fail_count++;
            $error("Control outputs active during reset");
        end

endmodule

bind dma_rd_top dma_rd_chk dma_rd_chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_ar           (o_ar),
    .i_arvalid      (o_arvalid),
    .i_arready      (i_arready),
    .i_rready       (o_rready),
    .i_strm         (o_strm),
    .i_strm_valid   (o_strm_valid),
    .i_strm_ready   (i_strm_ready),
    .i_status_valid (o_status_valid),
    .i_cmd_ready    (o_cmd_ready)
);

// File: verif/dma_rd_tb.sv
module dma_rd_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_rd_pkg::*;

    localparam int MAX_BEATS  = 16;
    localparam int FIFO_DEPTH = 8;
    // Beats over all tests are 8 + 40 + 20 + 12 + 24 + 8 + 10
    localparam int TOTAL_BEATS = 122;
    localparam int LIMIT       = 20 * TOTAL_BEATS + 200;

    logic        clk;
    logic        rst_n;
    dma_cmd_t    cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    strm_t       strm;
    logic        strm_valid;
    logic        strm_ready;
    logic [15:0] word_count;
    dma_status_t status;
    logic        status_valid;

    // Observed traffic as filled by the monitor
    axi_ar_t     ar_q [$];
    strm_t       strm_q [$];
    logic [15:0] cnt_q [$];
    dma_status_t status_q [$];
    // Expected traffic from the burst rule
    axi_ar_t     exp_ar_q [$];
    strm_t       exp_strm_q [$];
    logic [15:0] exp_cnt_q [$];
    dma_status_t exp_status_q [$];

    int   ar_done;
    int   strm_done;
    int   status_done;
    int   err_strm;
    int   err_ar;
    int   err_status;
    int   err_count;
    int   err_other;
    int   cycles;
    logic bp_en;

    tb_clk_gen #(.PERIOD(100)) clk_gen_i (.o_clk(clk));

    tb_axi_mem mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_ar      (ar),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_r       (r),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    dma_rd_top #(
        .MAX_BEATS  (MAX_BEATS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dma_rd_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_cmd          (cmd),
        .i_cmd_valid    (cmd_valid),
        .o_cmd_ready    (cmd_ready),
        .o_ar           (ar),
        .o_arvalid      (arvalid),
        .i_arready      (arready),
        .i_r            (r),
        .i_rvalid       (rvalid),
        .o_rready       (rready),
        .o_strm         (strm),
        .o_strm_valid   (strm_valid),
        .i_strm_ready   (strm_ready),
        .o_word_count   (word_count),
        .o_status       (status),
        .o_status_valid (status_valid)
    );

    // Monitor recording every completed transfer
    always @(posedge clk) begin
        if (rst_n) begin
            if (arvalid && arready) begin
                ar_q.push_back(ar);
            end
            if (strm_valid && strm_ready) begin
                strm_q.push_back(strm);
                cnt_q.push_back(word_count);
            end
            if (status_valid) begin
                status_q.push_back(status);
            end
        end
    end

    // Stream sink with random stalls when enabled
    initial begin
        strm_ready = 1'b1;
        forever begin
            @(posedge clk);
            #10;
            strm_ready = bp_en ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    end

    task automatic report_counts();
        $display("Errors: stream %0d, ar %0d, status %0d, count %0d, other %0d, assertion %0d",
                 err_strm, err_ar, err_status, err_count, err_other,
                 dma_rd_top_i.dma_rd_chk_i.fail_count);
    endtask

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT did not finish its commands", cycles);
        report_counts();
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp, input int idx);
        if (got !== exp) begin
            err_ar++;
            $display("Fail o_ar burst %0d: got %h exp %h", idx, got, exp);
        end
    endtask

    task automatic check_strm(input strm_t got, input strm_t exp, input int idx);
        if (got !== exp) begin
            err_strm++;
            $display("Fail o_strm word %0d: got %h exp %h", idx, got, exp);
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input int idx);
        if (got !== exp) begin
            err_count++;
            $display("Fail o_word_count word %0d: got %h exp %h", idx, got, exp);
        end
    endtask

    task automatic check_status(input dma_status_t got, input dma_status_t exp, input int idx);
        if (got !== exp) begin
            err_status++;
            $display("Fail o_status command %0d: got %h exp %h", idx, got, exp);
        end
    endtask

    // Bursts, words and status a command should produce
    task automatic expect_cmd(input dma_cmd_t c);
        int                left;
        int                n;
        int                b;
        int                idx;
        int                page_left;
        logic [ADDR_W-1:0] a;
        logic [1:0]        resp;
        axi_ar_t           x;
        strm_t             w;
        dma_status_t       s;
        left = int'(c.byte_len) / 4;
        a    = c.addr;
        resp = AXI_RESP_OKAY;
        idx  = 0;
        while (left > 0) begin
            n = (left < MAX_BEATS) ? left : MAX_BEATS;
            // Incrementing bursts stop at the page edge
            page_left = (PAGE_BYTES - int'(a % ADDR_W'(PAGE_BYTES))) / 4;
            if (!c.fixed && page_left < n) begin
                n = page_left;
            end
            x.addr  = a;
            x.len   = AXI_LEN_WIDTH'(n - 1);
            x.size  = AXI_SIZE_WORD;
            x.burst = c.fixed ? AXI_BURST_FIXED : AXI_BURST_INCR;
            x.lock  = c.lock;
            exp_ar_q.push_back(x);
            for (b = 0; b < n; b++) begin
                w.data = c.fixed ? a : a + ADDR_W'(4 * b);
                left--;
                idx++;
                w.last = (left == 0);
                exp_strm_q.push_back(w);
                exp_cnt_q.push_back(16'(idx));
                if (w.data >= 32'h8000_0000) begin
                    resp = resp | AXI_RESP_SLVERR;
                end
            end
            if (!c.fixed) begin
                a = a + ADDR_W'(4 * n);
            end
        end
        s.resp = resp;
        exp_status_q.push_back(s);
    endtask

    task automatic issue_cmd(input logic [ADDR_W-1:0] addr, input int words,
                             input logic fixed, input logic lock);
        dma_cmd_t c;
        c.addr     = addr;
        c.byte_len = 16'(words * 4);
        c.fixed    = fixed;
        c.lock     = lock;
        expect_cmd(c);
        @(posedge clk);
        #10;
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        while (!cmd_ready) begin
            @(posedge clk);
        end
        #10;
        cmd_valid = 1'b0;
    endtask

    // Wait for every expected word and status and then drain a few cycles
    task automatic wait_idle();
        while (status_q.size() < exp_status_q.size() || strm_q.size() < exp_strm_q.size()) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
    endtask

    task automatic compare_all(input string name);
        int i;
        if (ar_q.size() != exp_ar_q.size()) begin
            err_other++;
            $display("%s: %0d AR bursts issued, %0d expected", name, ar_q.size(), exp_ar_q.size());
        end
        for (i = ar_done; i < exp_ar_q.size() && i < ar_q.size(); i++) begin
            check_ar(ar_q[i], exp_ar_q[i], i);
        end
        ar_done = exp_ar_q.size();
        if (strm_q.size() != exp_strm_q.size()) begin
            err_other++;
            $display("%s: %0d stream words seen, %0d expected", name, strm_q.size(),
                     exp_strm_q.size());
        end
        for (i = strm_done; i < exp_strm_q.size() && i < strm_q.size(); i++) begin
            check_strm(strm_q[i], exp_strm_q[i], i);
            check_count(cnt_q[i], exp_cnt_q[i], i);
        end
        strm_done = exp_strm_q.size();
        // One status pulse per command
        if (status_q.size() != exp_status_q.size()) begin
            err_other++;
            $display("%s: %0d status pulses seen, %0d expected", name, status_q.size(),
                     exp_status_q.size());
        end
        for (i = status_done; i < exp_status_q.size() && i < status_q.size(); i++) begin
            check_status(status_q[i], exp_status_q[i], i);
        end
        status_done = exp_status_q.size();
    endtask

    task automatic single_incr_read();
        issue_cmd(32'h0000_0100, 8, 1'b0, 1'b0);
        wait_idle();
        compare_all("single incr");
    endtask

    // Sixteen words below a page edge so the second burst starts on it
    task automatic page_cross_read();
        issue_cmd(32'h0000_1FC0, 40, 1'b0, 1'b1);
        wait_idle();
        compare_all("page cross");
    endtask

    task automatic fixed_mode_read();
        issue_cmd(32'h0000_0300, 20, 1'b1, 1'b0);
        wait_idle();
        compare_all("fixed");
    endtask

    task automatic error_region_read();
        issue_cmd(32'h8000_0100, 12, 1'b0, 1'b0);
        wait_idle();
        compare_all("error region");
    endtask

    task automatic back_pressure_reads();
        bp_en = 1'b1;
        issue_cmd(32'h0000_0FF0, 24, 1'b0, 1'b0);
        issue_cmd(32'h0000_0040, 8, 1'b1, 1'b1);
        issue_cmd(32'h8000_0FF8, 10, 1'b0, 1'b1);
        wait_idle();
        bp_en = 1'b0;
        compare_all("back pressure");
    endtask

    initial begin
        void'($urandom(32'h23dd));
        rst_n       = 1'b0;
        cmd         = '0;
        cmd_valid   = 1'b0;
        bp_en       = 1'b0;
        ar_done     = 0;
        strm_done   = 0;
        status_done = 0;
        err_strm    = 0;
        err_ar      = 0;
        err_status  = 0;
        err_count   = 0;
        err_other   = 0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        single_incr_read();
        page_cross_read();
        fixed_mode_read();
        error_region_read();
        back_pressure_reads();

        report_counts();
        if (err_strm + err_ar + err_status + err_count + err_other == 0 &&
            dma_rd_top_i.dma_rd_chk_i.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: dma_rd_top.f
rtl/dma_rd_pkg.sv
rtl/dma_burst_split.sv
rtl/axi_mgr_rd.sv
rtl/rd_data_fifo.sv
rtl/dma_stream_out.sv
rtl/dma_rd_top.sv
verif/tb_clk_gen.sv
verif/tb_axi_mem.sv
verif/dma_rd_chk.sv
verif/dma_rd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA read testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module dma_rd_tb -f dma_rd_top.f -o sim_dma_rd; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dma_rd)
rc=$?
printf '%s\n' "$out"
if [ "$rc" -ne 0 ]; then
    echo "Simulation exited with status $rc"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
